// File: sec_xbar_pkg.sv
// secondary crossbar shared definitions
// bus widths, master and slave indices, address windows and the wide data word
package sec_xbar_pkg;

    localparam int SEC_WB_AW = 32;
    localparam int SEC_WB_DW = 128;
    localparam int SEC_WB_SW = SEC_WB_DW / 8;
    localparam int CPU_DW = 32;

    localparam int SEC_XBAR_NUM_MASTERS = 2;
    localparam int SEC_XBAR_NUM_SLAVES = 2;

    // the cpu slot also wins the first arbitration after reset
    localparam int SEC_XBAR_CPU_MASTER_IDX = 0;
    localparam int SEC_XBAR_VIDEO_MASTER_IDX = 1;

    // slave 0 is the frame memory window, slave 1 the peripheral window
    localparam logic [SEC_XBAR_NUM_SLAVES*SEC_WB_AW-1:0] SEC_XBAR_BASE_ADDRESSES = {
        32'h1000_0000,
        32'h0000_0000
    };
    localparam logic [SEC_XBAR_NUM_SLAVES*SEC_WB_AW-1:0] SEC_XBAR_MASKS = {
        32'hF000_0000,
        32'hF000_0000
    };

    // one 128-bit bus word seen as cpu lanes or as bytes, little endian
    typedef union packed {
        logic [SEC_WB_DW/CPU_DW-1:0][CPU_DW-1:0] lanes;
        logic [SEC_WB_SW-1:0][7:0] bytes;
    } wide_word_u;

endpackage

// File: wb_upsizer.sv
// Wishbone upsizer from the 32-bit cpu bus to the 128-bit crossbar bus
// write lanes follow the address, read lanes come back in order from a small FIFO
module wb_upsizer #(
    parameter int MAX_PENDING = 4
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,

    // narrow side, from the cpu
    input  logic                              i_scyc,
    input  logic                              i_sstb,
    input  logic                              i_swe,
    input  logic [sec_xbar_pkg::SEC_WB_AW-1:0] i_saddr,
    input  logic [sec_xbar_pkg::CPU_DW-1:0]    i_sdata,
    input  logic [sec_xbar_pkg::CPU_DW/8-1:0]  i_ssel,
    output logic                              o_sstall,
    output logic                              o_sack,
    output logic [sec_xbar_pkg::CPU_DW-1:0]    o_sdata,
    output logic                              o_serr,

    // wide side, towards the crossbar
    output logic                              o_wcyc,
    output logic                              o_wstb,
    output logic                              o_wwe,
    output logic [sec_xbar_pkg::SEC_WB_AW-1:0] o_waddr,
    output logic [sec_xbar_pkg::SEC_WB_DW-1:0] o_wdata,
    output logic [sec_xbar_pkg::SEC_WB_SW-1:0] o_wsel,
    input  logic                              i_wstall,
    input  logic                              i_wack,
    input  logic [sec_xbar_pkg::SEC_WB_DW-1:0] i_wdata,
    input  logic                              i_werr
);

    localparam int AW = sec_xbar_pkg::SEC_WB_AW;
    localparam int SW = sec_xbar_pkg::SEC_WB_SW;
    localparam int LANE_BYTES = sec_xbar_pkg::CPU_DW / 8;
    localparam int LANES = sec_xbar_pkg::SEC_WB_DW / sec_xbar_pkg::CPU_DW;
    localparam int LANE_W = $clog2(LANES);
    localparam int LANE_LSB = $clog2(LANE_BYTES);
    localparam int WORD_LSB = $clog2(SW);
    localparam int PTR_W = (MAX_PENDING > 1) ? $clog2(MAX_PENDING) : 1;
    localparam int CNT_W = $clog2(MAX_PENDING + 1);

    logic [LANE_W-1:0] lane;
    logic [LANE_W-1:0] lane_fifo [MAX_PENDING];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              push;
    logic              pop;
    sec_xbar_pkg::wide_word_u wr_word;
    sec_xbar_pkg::wide_word_u rd_word;

    assign lane = i_saddr[LANE_LSB +: LANE_W];
    assign full = (count == CNT_W'(MAX_PENDING));

    // request side, no added latency
    assign o_wcyc = i_scyc;
    assign o_wstb = i_sstb && !full;
    assign o_wwe = i_swe;
    assign o_waddr = {i_saddr[AW-1:WORD_LSB], {WORD_LSB{1'b0}}};
    assign wr_word.lanes = {LANES{i_sdata}};
    assign o_wdata = wr_word;
    assign o_wsel = SW'(i_ssel) << (lane * LANE_BYTES);

    // a full FIFO holds the cpu back before anything reaches the crossbar
    assign o_sstall = full || i_wstall;
    assign push = i_scyc && i_sstb && !o_sstall;
    assign pop = i_wack || i_werr;

    // response side picks the lane recorded at acceptance
    assign rd_word = i_wdata;
    assign o_sdata = rd_word.lanes[lane_fifo[rd_ptr]];
    assign o_sack = i_wack;
    assign o_serr = i_werr;

    always_ff @(posedge i_clk) begin
        if (push) begin
            lane_fifo[wr_ptr] <= lane;
        end
    end

    always_ff @(posedge i_clk) begin
        // dropping cyc abandons anything still outstanding
        if (!i_rst_n || !i_scyc) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(MAX_PENDING - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(MAX_PENDING - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

// File: wb_xbar.sv
// pipelined Wishbone crossbar for the secondary bus
// per-slave round-robin grants, address decode and an error slave for unmapped accesses
module wb_xbar #(
    localparam int NM = sec_xbar_pkg::SEC_XBAR_NUM_MASTERS,
    localparam int NS = sec_xbar_pkg::SEC_XBAR_NUM_SLAVES,
    localparam int AW = sec_xbar_pkg::SEC_WB_AW,
    localparam int DW = sec_xbar_pkg::SEC_WB_DW,
    localparam int SW = sec_xbar_pkg::SEC_WB_SW,
    parameter logic [NS*AW-1:0] SLAVE_ADDR = sec_xbar_pkg::SEC_XBAR_BASE_ADDRESSES,
    parameter logic [NS*AW-1:0] SLAVE_MASK = sec_xbar_pkg::SEC_XBAR_MASKS
) (
    input  logic            i_clk,
    input  logic            i_rst_n,

    // master side
    input  logic [NM-1:0]    i_mcyc,
    input  logic [NM-1:0]    i_mstb,
    input  logic [NM-1:0]    i_mwe,
    input  logic [NM*AW-1:0] i_maddr,
    input  logic [NM*DW-1:0] i_mdata,
    input  logic [NM*SW-1:0] i_msel,
    output logic [NM-1:0]    o_mstall,
    output logic [NM-1:0]    o_mack,
    output logic [NM*DW-1:0] o_mdata,
    output logic [NM-1:0]    o_merr,

    // slave side
    output logic [NS-1:0]    o_scyc,
    output logic [NS-1:0]    o_sstb,
    output logic [NS-1:0]    o_swe,
    output logic [NS*AW-1:0] o_saddr,
    output logic [NS*DW-1:0] o_sdata,
    output logic [NS*SW-1:0] o_ssel,
    input  logic [NS-1:0]    i_sstall,
    input  logic [NS-1:0]    i_sack,
    input  logic [NS*DW-1:0] i_sdata,
    input  logic [NS-1:0]    i_serr
);

    localparam int MI_W = (NM > 1) ? $clog2(NM) : 1;
    // last points at the slot before the cpu, so the cpu wins first
    localparam int RR_INIT = (sec_xbar_pkg::SEC_XBAR_CPU_MASTER_IDX + NM - 1) % NM;

    logic [NS-1:0]   hit [NM];
    logic [NM-1:0]   unmapped;
    logic [NM-1:0]   holds;
    logic [NS-1:0]   sgnt_valid;
    logic [MI_W-1:0] sgnt_idx [NS];
    logic [MI_W-1:0] last [NS];
    logic [NS-1:0]   pick_valid;
    logic [MI_W-1:0] pick_idx [NS];
    logic [NM-1:0]   err_gnt;
    logic [NM-1:0]   err_acc;
    logic [NM-1:0]   err_pending;

    // decode and grant bookkeeping
    always_comb begin
        holds = err_gnt;
        for (int m = 0; m < NM; m++) begin
            for (int s = 0; s < NS; s++) begin
                hit[m][s] = (i_maddr[m*AW +: AW] & SLAVE_MASK[s*AW +: AW])
                            == SLAVE_ADDR[s*AW +: AW];
            end
            unmapped[m] = ~|hit[m];
            err_acc[m] = err_gnt[m] && i_mcyc[m] && i_mstb[m] && unmapped[m];
        end
        for (int s = 0; s < NS; s++) begin
            if (sgnt_valid[s]) begin
                holds[sgnt_idx[s]] = 1'b1;
            end
        end
    end

    // round robin, starting one past the last winner of each slave
    always_comb begin
        int cand;
        for (int s = 0; s < NS; s++) begin
            pick_valid[s] = 1'b0;
            pick_idx[s] = '0;
            for (int k = 1; k <= NM; k++) begin
                cand = (int'(last[s]) + k) % NM;
                if (!pick_valid[s] && i_mcyc[cand] && i_mstb[cand] && hit[cand][s]
                        && !holds[cand]) begin
                    pick_valid[s] = 1'b1;
                    pick_idx[s] = MI_W'(cand);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sgnt_valid <= '0;
            err_gnt <= '0;
            err_pending <= '0;
            for (int s = 0; s < NS; s++) begin
                sgnt_idx[s] <= '0;
                last[s] <= MI_W'(RR_INIT);
            end
        end else begin
            for (int s = 0; s < NS; s++) begin
                if (sgnt_valid[s]) begin
                    // the owner keeps the slave until it drops cyc
                    if (!i_mcyc[sgnt_idx[s]]) begin
                        sgnt_valid[s] <= 1'b0;
                    end
                end else if (pick_valid[s]) begin
                    sgnt_valid[s] <= 1'b1;
                    sgnt_idx[s] <= pick_idx[s];
                    last[s] <= pick_idx[s];
                end
            end
            for (int m = 0; m < NM; m++) begin
                if (!i_mcyc[m]) begin
                    err_gnt[m] <= 1'b0;
                end else if (i_mstb[m] && unmapped[m] && !holds[m]) begin
                    err_gnt[m] <= 1'b1;
                end
            end
            // error slave answers one cycle after each accepted request
            err_pending <= err_acc;
        end
    end

    // request routing towards the slaves
    always_comb begin
        int own;
        for (int s = 0; s < NS; s++) begin
            own = int'(sgnt_idx[s]);
            o_scyc[s] = sgnt_valid[s] && i_mcyc[own];
            o_sstb[s] = sgnt_valid[s] && i_mcyc[own] && i_mstb[own] && hit[own][s];
            o_swe[s] = i_mwe[own];
            o_saddr[s*AW +: AW] = i_maddr[own*AW +: AW];
            o_sdata[s*DW +: DW] = i_mdata[own*DW +: DW];
            o_ssel[s*SW +: SW] = i_msel[own*SW +: SW];
        end
    end

    // responses back to the granted masters
    always_comb begin
        int own;
        for (int m = 0; m < NM; m++) begin
            o_mstall[m] = !err_acc[m];
            o_mack[m] = 1'b0;
            o_merr[m] = err_pending[m];
            o_mdata[m*DW +: DW] = '0;
        end
        for (int s = 0; s < NS; s++) begin
            own = int'(sgnt_idx[s]);
            if (sgnt_valid[s]) begin
                // a request to another window stays stalled
                if (hit[own][s]) begin
                    o_mstall[own] = i_sstall[s];
                end
                o_mack[own] = i_sack[s];
                o_merr[own] = o_merr[own] || i_serr[s];
                o_mdata[own*DW +: DW] = i_sdata[s*DW +: DW];
            end
        end
    end

endmodule

// File: sec_xbar.sv
// secondary crossbar of the video platform
// cpu through the upsizer and the video core share the frame memory and peripheral windows
module sec_xbar #(
    parameter int MAX_PENDING = 4,
    localparam int NS = sec_xbar_pkg::SEC_XBAR_NUM_SLAVES,
    localparam int AW = sec_xbar_pkg::SEC_WB_AW,
    localparam int DW = sec_xbar_pkg::SEC_WB_DW,
    localparam int SW = sec_xbar_pkg::SEC_WB_SW
) (
    input  logic            i_clk,
    input  logic            i_rst_n,

    input  logic            i_cpu_cyc,
    input  logic            i_cpu_stb,
    input  logic            i_cpu_we,
    input  logic [AW-1:0]   i_cpu_addr,
    input  logic [31:0]     i_cpu_wdata,
    input  logic [3:0]      i_cpu_sel,
    output logic            o_cpu_stall,
    output logic            o_cpu_ack,
    output logic [31:0]     o_cpu_rdata,
    output logic            o_cpu_err,

    input  logic            i_vid_cyc,
    input  logic            i_vid_stb,
    input  logic            i_vid_we,
    input  logic [AW-1:0]   i_vid_addr,
    input  logic [DW-1:0]   i_vid_wdata,
    input  logic [SW-1:0]   i_vid_sel,
    output logic            o_vid_stall,
    output logic            o_vid_ack,
    output logic [DW-1:0]   o_vid_rdata,
    output logic            o_vid_err,

    output logic [NS-1:0]    o_s_cyc,
    output logic [NS-1:0]    o_s_stb,
    output logic [NS-1:0]    o_s_we,
    output logic [NS*AW-1:0] o_s_addr,
    output logic [NS*DW-1:0] o_s_wdata,
    output logic [NS*SW-1:0] o_s_sel,
    input  logic [NS-1:0]    i_s_stall,
    input  logic [NS-1:0]    i_s_ack,
    input  logic [NS*DW-1:0] i_s_rdata,
    input  logic [NS-1:0]    i_s_err
);

    localparam int NM = sec_xbar_pkg::SEC_XBAR_NUM_MASTERS;
    localparam int CPU = sec_xbar_pkg::SEC_XBAR_CPU_MASTER_IDX;
    localparam int VID = sec_xbar_pkg::SEC_XBAR_VIDEO_MASTER_IDX;

    logic [NM-1:0]    mcyc;
    logic [NM-1:0]    mstb;
    logic [NM-1:0]    mwe;
    logic [NM*AW-1:0] maddr;
    logic [NM*DW-1:0] mwdata;
    logic [NM*SW-1:0] msel;
    logic [NM-1:0]    mstall;
    logic [NM-1:0]    mack;
    logic [NM*DW-1:0] mrdata;
    logic [NM-1:0]    merr;

    // cpu goes 32 to 128 bits before it takes its master slot
    wb_upsizer #(
        .MAX_PENDING(MAX_PENDING)
    ) u_upsizer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_scyc  (i_cpu_cyc),
        .i_sstb  (i_cpu_stb),
        .i_swe   (i_cpu_we),
        .i_saddr (i_cpu_addr),
        .i_sdata (i_cpu_wdata),
        .i_ssel  (i_cpu_sel),
        .o_sstall(o_cpu_stall),
        .o_sack  (o_cpu_ack),
        .o_sdata (o_cpu_rdata),
        .o_serr  (o_cpu_err),
        .o_wcyc  (mcyc[CPU]),
        .o_wstb  (mstb[CPU]),
        .o_wwe   (mwe[CPU]),
        .o_waddr (maddr[CPU*AW +: AW]),
        .o_wdata (mwdata[CPU*DW +: DW]),
        .o_wsel  (msel[CPU*SW +: SW]),
        .i_wstall(mstall[CPU]),
        .i_wack  (mack[CPU]),
        .i_wdata (mrdata[CPU*DW +: DW]),
        .i_werr  (merr[CPU])
    );

    // video core is already bus width
    assign mcyc[VID] = i_vid_cyc;
    assign mstb[VID] = i_vid_stb;
    assign mwe[VID] = i_vid_we;
    assign maddr[VID*AW +: AW] = i_vid_addr;
    assign mwdata[VID*DW +: DW] = i_vid_wdata;
    assign msel[VID*SW +: SW] = i_vid_sel;
    assign o_vid_stall = mstall[VID];
    assign o_vid_ack = mack[VID];
    assign o_vid_rdata = mrdata[VID*DW +: DW];
    assign o_vid_err = merr[VID];

    wb_xbar #(
        .SLAVE_ADDR(sec_xbar_pkg::SEC_XBAR_BASE_ADDRESSES),
        .SLAVE_MASK(sec_xbar_pkg::SEC_XBAR_MASKS)
    ) u_xbar (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_mcyc  (mcyc),
        .i_mstb  (mstb),
        .i_mwe   (mwe),
        .i_maddr (maddr),
        .i_mdata (mwdata),
        .i_msel  (msel),
        .o_mstall(mstall),
        .o_mack  (mack),
        .o_mdata (mrdata),
        .o_merr  (merr),
        .o_scyc  (o_s_cyc),
        .o_sstb  (o_s_stb),
        .o_swe   (o_s_we),
        .o_saddr (o_s_addr),
        .o_sdata (o_s_wdata),
        .o_ssel  (o_s_sel),
        .i_sstall(i_s_stall),
        .i_sack  (i_s_ack),
        .i_sdata (i_s_rdata),
        .i_serr  (i_s_err)
    );

endmodule

// File: sec_xbar_properties.sv
// protocol assertions for the secondary crossbar top level
module sec_xbar_properties (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       i_cpu_cyc,
    input logic       o_cpu_ack,
    input logic       o_cpu_err,
    input logic       i_vid_cyc,
    input logic       o_vid_ack,
    input logic       o_vid_err,
    input logic [1:0] o_s_cyc
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    cpu_resp_needs_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_cpu_ack || o_cpu_err) |-> i_cpu_cyc)
        else begin
            fail_count++;
            $error("cpu response while cyc is low");
        end

    vid_resp_needs_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_vid_ack || o_vid_err) |-> i_vid_cyc)
        else begin
            fail_count++;
            $error("video response while cyc is low");
        end

    cpu_single_resp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_cpu_ack && o_cpu_err))
        else begin
            fail_count++;
            $error("cpu ack and err in the same cycle");
        end

    vid_single_resp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_vid_ack && o_vid_err))
        else begin
            fail_count++;
            $error("video ack and err in the same cycle");
        end

    // grants are cleared by the first reset edge
    no_cyc_in_reset: assert property (@(posedge i_clk)
        (!i_rst_n && $past(!i_rst_n)) |-> o_s_cyc == 2'b00)
        else begin
            fail_count++;
            $error("slave cyc raised during reset");
        end

endmodule

bind sec_xbar sec_xbar_properties u_props (.*);

// File: tb_checker.sv
// response checker for the secondary crossbar
// keeps a byte shadow of both windows and compares every ack and err with its request
module tb_checker (
    input logic         i_clk,
    input logic         i_rst_n,
    input logic         i_cpu_cyc,
    input logic         i_cpu_stb,
    input logic         i_cpu_we,
    input logic [31:0]  i_cpu_addr,
    input logic [31:0]  i_cpu_wdata,
    input logic [3:0]   i_cpu_sel,
    input logic         i_cpu_stall,
    input logic         i_cpu_ack,
    input logic [31:0]  i_cpu_rdata,
    input logic         i_cpu_err,
    input logic         i_vid_cyc,
    input logic         i_vid_stb,
    input logic         i_vid_we,
    input logic [31:0]  i_vid_addr,
    input logic [127:0] i_vid_wdata,
    input logic [15:0]  i_vid_sel,
    input logic         i_vid_stall,
    input logic         i_vid_ack,
    input logic [127:0] i_vid_rdata,
    input logic         i_vid_err,
    input logic [1:0]   i_s_stb,
    input logic [63:0]  i_s_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [15:0]  row;
        logic         exp_err;
        logic         pred_err;
        logic         we;
        logic [15:0]  mask;
        logic [127:0] data;
    } entry_t;

    // table tags from the stimulus, then predictions in acceptance order
    logic [16:0] tags [2][$];
    entry_t      pend [2][$];
    logic [7:0]  shadow [logic [31:0]];
    int n_pass = 0;
    int n_fail = 0;
    int n_other = 0;

    function automatic string name(input int m);
        return (m == 0) ? "cpu" : "video";
    endfunction

    task automatic add_row(input int m, input int row, input bit exp_err);
        tags[m].push_back({exp_err, 16'(row)});
    endtask

    task automatic accept(input int m, input bit we, input logic [31:0] addr,
                          input logic [127:0] wdata, input logic [15:0] sel);
        entry_t e;
        logic [16:0] tag;
        logic [31:0] a;
        sec_xbar_pkg::wide_word_u w;
        sec_xbar_pkg::wide_word_u want;
        w = wdata;
        want = '0;
        if (tags[m].size() == 0) begin
            n_other++;
            $display("%s request accepted that the stimulus never issued", name(m));
            return;
        end
        tag = tags[m].pop_front();
        e.row = tag[15:0];
        e.exp_err = tag[16];
        e.we = we;
        e.mask = sel;
        // only the two lowest 256 MB windows are mapped
        e.pred_err = addr[31:28] > 4'd1;
        for (int i = 0; i < 16; i++) begin
            a = {addr[31:4], 4'(i)};
            if (sel[i] && !e.pred_err) begin
                if (we) begin
                    shadow[a] = w.bytes[i];
                end else if (shadow.exists(a)) begin
                    want.bytes[i] = shadow[a];
                end else begin
                    n_other++;
                    $display("test %0d reads byte %h that was never written", e.row, a);
                end
            end
        end
        e.data = want;
        pend[m].push_back(e);
    endtask

    task automatic respond(input int m, input bit ack, input bit err,
                           input logic [127:0] rdata);
        entry_t e;
        string msg;
        sec_xbar_pkg::wide_word_u got;
        sec_xbar_pkg::wide_word_u want;
        if (!ack && !err) begin
            return;
        end
        if (pend[m].size() == 0) begin
            n_other++;
            $display("%s got a response with nothing outstanding", name(m));
            return;
        end
        e = pend[m].pop_front();
        got = rdata;
        want = e.data;
        msg = "";
        if (ack && err) begin
            msg = "ack and err together";
        end else if (err != e.exp_err) begin
            msg = $sformatf("expected %s, got %s", e.exp_err ? "err" : "ack", err ? "err" : "ack");
        end else if (err != e.pred_err) begin
            msg = "response kind disagrees with the address map";
        end else if (!e.we && ack) begin
            for (int i = 0; i < 16; i++) begin
                if (e.mask[i] && got.bytes[i] !== want.bytes[i]) begin
                    msg = $sformatf("byte %0d read %h, expected %h", i, got.bytes[i],
                                    want.bytes[i]);
                end
            end
        end
        if (msg == "") begin
            n_pass++;
            $display("test %0d: %s %s %s ok", e.row, name(m), e.we ? "write" : "read",
                     err ? "err" : "ack");
        end else begin
            n_fail++;
            $display("FAIL %0t: test %0d %s", $time, e.row, msg);
        end
    endtask

    // responses belong to earlier requests, so they go first
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            respond(0, i_cpu_ack, i_cpu_err, {4{i_cpu_rdata}});
            respond(1, i_vid_ack, i_vid_err, i_vid_rdata);
            if (i_cpu_cyc && i_cpu_stb && !i_cpu_stall) begin
                accept(0, i_cpu_we, i_cpu_addr, {4{i_cpu_wdata}},
                       16'(i_cpu_sel) << (4 * i_cpu_addr[3:2]));
            end
            if (i_vid_cyc && i_vid_stb && !i_vid_stall) begin
                accept(1, i_vid_we, i_vid_addr, i_vid_wdata, i_vid_sel);
            end
            for (int s = 0; s < 2; s++) begin
                if (i_s_stb[s] && i_s_addr[s*32+28 +: 4] != 4'(s)) begin
                    n_fail++;
                    $display("FAIL %0t: slave %0d strobed for address %h", $time, s,
                             i_s_addr[s*32 +: 32]);
                end
            end
        end
    end

endmodule

// File: tb_sec_xbar.sv
// testbench for the secondary crossbar
// table driven masters, two slave memories with random stalls, timeout and summary
module tb_sec_xbar;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS = 18;
    localparam int RESET_CYCLES = 3;
    localparam int LIMIT = NROWS * 40 + RESET_CYCLES;

    logic         i_clk;
    logic         i_rst_n;
    logic         i_cpu_cyc;
    logic         i_cpu_stb;
    logic         i_cpu_we;
    logic [31:0]  i_cpu_addr;
    logic [31:0]  i_cpu_wdata;
    logic [3:0]   i_cpu_sel;
    logic         o_cpu_stall;
    logic         o_cpu_ack;
    logic [31:0]  o_cpu_rdata;
    logic         o_cpu_err;
    logic         i_vid_cyc;
    logic         i_vid_stb;
    logic         i_vid_we;
    logic [31:0]  i_vid_addr;
    logic [127:0] i_vid_wdata;
    logic [15:0]  i_vid_sel;
    logic         o_vid_stall;
    logic         o_vid_ack;
    logic [127:0] o_vid_rdata;
    logic         o_vid_err;
    logic [1:0]   o_s_cyc;
    logic [1:0]   o_s_stb;
    logic [1:0]   o_s_we;
    logic [63:0]  o_s_addr;
    logic [255:0] o_s_wdata;
    logic [31:0]  o_s_sel;
    logic [1:0]   i_s_stall = '0;
    logic [1:0]   i_s_ack = '0;
    logic [255:0] i_s_rdata = '0;
    logic [1:0]   i_s_err = '0;

    // stimulus table where rows of one group run together
    int           t_grp [NROWS];
    int           t_mst [NROWS];
    bit           t_we [NROWS];
    logic [31:0]  t_addr [NROWS];
    logic [127:0] t_data [NROWS];
    logic [15:0]  t_sel [NROWS];
    bit           t_err [NROWS];
    int           nrow = 0;

    int          cycle_count = 0;
    int          cpu_resps = 0;
    int          vid_resps = 0;
    logic [31:0] lfsr = 32'hb2214f79;

    // slave model state captured mid-cycle
    logic [1:0]               acc;
    logic                     cap_we [2];
    logic [31:0]              cap_addr [2];
    logic [15:0]              cap_sel [2];
    sec_xbar_pkg::wide_word_u cap_data [2];
    sec_xbar_pkg::wide_word_u slave_mem [logic [28:0]];

    sec_xbar #(
        .MAX_PENDING(4)
    ) DUT (.*);

    tb_checker chk (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_cpu_cyc(i_cpu_cyc), .i_cpu_stb(i_cpu_stb), .i_cpu_we(i_cpu_we),
        .i_cpu_addr(i_cpu_addr), .i_cpu_wdata(i_cpu_wdata), .i_cpu_sel(i_cpu_sel),
        .i_cpu_stall(o_cpu_stall), .i_cpu_ack(o_cpu_ack), .i_cpu_rdata(o_cpu_rdata),
        .i_cpu_err(o_cpu_err),
        .i_vid_cyc(i_vid_cyc), .i_vid_stb(i_vid_stb), .i_vid_we(i_vid_we),
        .i_vid_addr(i_vid_addr), .i_vid_wdata(i_vid_wdata), .i_vid_sel(i_vid_sel),
        .i_vid_stall(o_vid_stall), .i_vid_ack(o_vid_ack), .i_vid_rdata(o_vid_rdata),
        .i_vid_err(o_vid_err),
        .i_s_stb(o_s_stb), .i_s_addr(o_s_addr)
    );

    function automatic bit next_bit();
        bit b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    // unwritten lines read back a pattern made from their address
    function automatic logic [127:0] fill(input logic [31:0] a);
        return {a ^ 32'h9e37_79b9, ~a, a ^ 32'h5bd1_e995, {a[15:0], a[31:16]}};
    endfunction

    task automatic put(input int grp, input int mst, input bit we, input logic [31:0] addr,
                       input logic [127:0] data, input logic [15:0] sel, input bit err);
        t_grp[nrow] = grp;
        t_mst[nrow] = mst;
        t_we[nrow] = we;
        t_addr[nrow] = addr;
        t_data[nrow] = data;
        t_sel[nrow] = sel;
        t_err[nrow] = err;
        nrow++;
    endtask

    task automatic load_table();
        put(0, 0, 1, 32'h0000_0104, 128'hcafe_f00d, 16'h000f, 0);
        put(1, 0, 0, 32'h0000_0104, 128'h0, 16'h000f, 0);
        put(2, 1, 1, 32'h0000_0200, 128'h8f8e8d8c_8b8a8988_87868584_83828180, 16'hffff, 0);
        put(3, 0, 1, 32'h0000_0208, 128'h1122_3344, 16'h0006, 0);
        put(4, 1, 0, 32'h0000_0200, 128'h0, 16'hffff, 0);
        put(5, 1, 1, 32'h1000_0040, 128'h01234567_89abcdef_fedcba98_76543210, 16'hffff, 0);
        put(6, 1, 1, 32'h1000_0040, 128'hdeadbeef_0badf00d_a5a5a5a5_5a5a5a5a, 16'h0ff0, 0);
        put(7, 1, 0, 32'h1000_0040, 128'h0, 16'hffff, 0);
        // unmapped from both masters at once
        put(8, 0, 0, 32'h2000_0000, 128'h0, 16'h000f, 1);
        put(8, 1, 1, 32'h8000_0010, 128'h55, 16'hffff, 1);
        // both masters on slave 0 in the same cycle
        put(9, 0, 1, 32'h0000_0300, 128'h7654_3210, 16'h000f, 0);
        put(9, 0, 0, 32'h0000_0104, 128'h0, 16'h000f, 0);
        put(9, 1, 1, 32'h0000_0400, 128'hfeedface_c0ffee00_12345678_9abcdef0, 16'hffff, 0);
        put(9, 1, 0, 32'h0000_0200, 128'h0, 16'hffff, 0);
        // four pipelined cpu reads over different lanes
        put(10, 0, 0, 32'h0000_0104, 128'h0, 16'h000f, 0);
        put(10, 0, 0, 32'h0000_020c, 128'h0, 16'h000f, 0);
        put(10, 0, 0, 32'h0000_0200, 128'h0, 16'h000f, 0);
        put(10, 0, 0, 32'h0000_0208, 128'h0, 16'h000f, 0);
    endtask

    task automatic drive(input int m, input bit cyc, input bit stb, input int r);
        if (m == 0) begin
            i_cpu_cyc = cyc;
            i_cpu_stb = stb;
            i_cpu_we = t_we[r];
            i_cpu_addr = t_addr[r];
            i_cpu_wdata = t_data[r][31:0];
            i_cpu_sel = t_sel[r][3:0];
        end else begin
            i_vid_cyc = cyc;
            i_vid_stb = stb;
            i_vid_we = t_we[r];
            i_vid_addr = t_addr[r];
            i_vid_wdata = t_data[r];
            i_vid_sel = t_sel[r];
        end
    endtask

    function automatic bit stalled(input int m);
        return (m == 0) ? o_cpu_stall : o_vid_stall;
    endfunction

    function automatic int responses(input int m);
        return (m == 0) ? cpu_resps : vid_resps;
    endfunction

    // issue one master's rows of a group as pipelined requests in one cyc
    task automatic run_master(input int m, input int g);
        int rows[$];
        int target;
        for (int r = 0; r < nrow; r++) begin
            if (t_grp[r] == g && t_mst[r] == m) begin
                rows.push_back(r);
            end
        end
        if (rows.size() == 0) begin
            return;
        end
        target = responses(m) + rows.size();
        foreach (rows[i]) begin
            drive(m, 1'b1, 1'b1, rows[i]);
            chk.add_row(m, rows[i], t_err[rows[i]]);
            @(negedge i_clk);
            while (stalled(m)) begin
                @(negedge i_clk);
            end
            @(posedge i_clk);
            #2;
        end
        drive(m, 1'b1, 1'b0, rows[rows.size()-1]);
        while (responses(m) != target) begin
            @(posedge i_clk);
            #2;
        end
        drive(m, 1'b0, 1'b0, rows[rows.size()-1]);
    endtask

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
    end

    always @(negedge i_clk) begin
        cpu_resps += int'(o_cpu_ack || o_cpu_err);
        vid_resps += int'(o_vid_ack || o_vid_err);
        for (int s = 0; s < 2; s++) begin
            acc[s] = i_rst_n && o_s_cyc[s] && o_s_stb[s] && !i_s_stall[s];
            cap_we[s] = o_s_we[s];
            cap_addr[s] = o_s_addr[s*32 +: 32];
            cap_sel[s] = o_s_sel[s*16 +: 16];
            cap_data[s] = o_s_wdata[s*128 +: 128];
        end
    end

    // slave memories answer one cycle after acceptance
    always @(posedge i_clk) begin
        logic [28:0] key;
        sec_xbar_pkg::wide_word_u w;
        #2;
        for (int s = 0; s < 2; s++) begin
            i_s_ack[s] = acc[s];
            if (acc[s]) begin
                key = {1'(s), cap_addr[s][31:4]};
                w = slave_mem.exists(key) ? slave_mem[key] : fill(cap_addr[s]);
                if (cap_we[s]) begin
                    for (int i = 0; i < 16; i++) begin
                        if (cap_sel[s][i]) begin
                            w.bytes[i] = cap_data[s].bytes[i];
                        end
                    end
                    slave_mem[key] = w;
                end else begin
                    i_s_rdata[s*128 +: 128] = w;
                end
            end
            i_s_stall[s] = i_rst_n && next_bit() && next_bit();
        end
    end

    initial begin
        wait (cycle_count == LIMIT);
        $display("timeout: no finish after %0d cycles", LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        i_rst_n = 1'b0;
        load_table();
        // both masters already request slave 0 while reset is held
        drive(0, 1'b1, 1'b1, 0);
        drive(1, 1'b1, 1'b1, 0);
        repeat (RESET_CYCLES) @(posedge i_clk);
        #2;
        drive(0, 1'b0, 1'b0, 0);
        drive(1, 1'b0, 1'b0, 0);
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #2;
        for (int g = 0; g <= t_grp[nrow-1]; g++) begin
            fork
                run_master(0, g);
                run_master(1, g);
            join
            @(posedge i_clk);
            #2;
        end
        repeat (3) @(posedge i_clk);
        if (chk.n_pass + chk.n_fail != NROWS) begin
            $display("only %0d of %0d tests got a response", chk.n_pass + chk.n_fail, NROWS);
        end
        $display("tests: %0d passed, %0d failed, %0d other errors, %0d assertion failures",
                 chk.n_pass, chk.n_fail, chk.n_other, DUT.u_props.fail_count);
        if (chk.n_fail == 0 && chk.n_other == 0 && chk.n_pass == NROWS
                && DUT.u_props.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
sec_xbar_pkg.sv
wb_upsizer.sv
wb_xbar.sv
sec_xbar.sv
sec_xbar_properties.sv
tb_checker.sv
tb_sec_xbar.sv

// File: run.sh
#!/bin/sh
# compile and run the secondary crossbar testbench with Verilator
set -e
verilator --binary --timing --assert --top-module tb_sec_xbar -f src.f -o tb_sec_xbar
./obj_dir/tb_sec_xbar | tee sim.log
if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
